// File: src/rt_pkg.sv
//==========================================================================
// Shared sizes, sample types and FSM encodings for the ADC channel router.
// Modules import this package inside their bodies and use scoped names
// in their port lists.
//==========================================================================

`default_nettype none

package rt_pkg;

  // physical ADC channels entering the front end
  localparam int phys_channels = 8;

  // mux sources: raw channels 0..7, then their first differences 8..15
  localparam int input_channels = 2 * phys_channels;

  // logical channels leaving the mux
  localparam int output_channels = 8;

  // sample and source index widths
  localparam int sample_width = 16;
  localparam int select_bits = $clog2(input_channels);

  // one configuration word, nibble j selects the source of output j
  localparam int config_width = output_channels * select_bits;

  // signed ADC sample
  typedef logic signed [sample_width-1:0] sample_t;

  // index of one mux source
  typedef logic [select_bits-1:0] select_t;

  // saturation limits of the difference stage
  localparam sample_t sample_max = sample_t'(16'sh7fff);
  localparam sample_t sample_min = sample_t'(16'sh8000);

  // config-side FSM of the toggle handshake CDC
  typedef enum logic {
    cdc_idle,
    cdc_wait_ack
  } cdc_src_state_t;

endpackage

`default_nettype wire

// File: src/config_reg_cdc.sv
//==========================================================================
// Moves one configuration word from config_clk into data_clk using a
// request/acknowledge toggle pair. config_ready drops after acceptance and
// comes back once the data side has loaded the word and acknowledged.
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module config_reg_cdc (
  input  wire logic                           config_clk,
  input  wire logic                           config_reset,
  input  wire logic [rt_pkg::config_width-1:0] config_data,
  input  wire logic                           config_valid,
  output logic                                config_ready,
  input  wire logic                           data_clk,
  input  wire logic                           data_reset,
  output logic      [rt_pkg::config_width-1:0] sel_word,
  output logic                                sel_update
);

  import rt_pkg::*;

  // config_clk side
  cdc_src_state_t src_state;
  // word is held here for the whole transfer, so the data side can sample it
  logic [config_width-1:0] word_latch;
  logic req_toggle;
  logic ack_meta;
  logic ack_sync;

  // data_clk side
  logic req_meta;
  logic req_sync;
  // last request level seen, doubles as the acknowledge toggle
  logic ack_toggle;
  logic req_change;

  // source FSM: accept, flip the request, wait for the matching ack level
  always_ff @(posedge config_clk) begin
    if (config_reset) begin
      src_state    <= cdc_idle;
      req_toggle   <= 1'b0;
      config_ready <= 1'b1;
    end else begin
      case (src_state)
        cdc_idle: begin
          if (config_valid && config_ready) begin
            req_toggle   <= ~req_toggle;
            config_ready <= 1'b0;
            src_state    <= cdc_wait_ack;
          end
        end
        cdc_wait_ack: begin
          // ack level matches request once the data side has loaded the word
          if (ack_sync == req_toggle) begin
            config_ready <= 1'b1;
            src_state    <= cdc_idle;
          end
        end
        default: begin
          src_state <= cdc_idle;
        end
      endcase
    end
  end

  // word capture, payload only
  always_ff @(posedge config_clk) begin
    if ((src_state == cdc_idle) && config_valid && config_ready) begin
      word_latch <= config_data;
    end
  end

  // ack toggle back into config_clk, two flops
  always_ff @(posedge config_clk) begin
    if (config_reset) begin
      ack_meta <= 1'b0;
      ack_sync <= 1'b0;
    end else begin
      ack_meta <= ack_toggle;
      ack_sync <= ack_meta;
    end
  end

  // request toggle into data_clk, two flops plus edge detect
  assign req_change = req_sync ^ ack_toggle;

  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      req_meta   <= 1'b0;
      req_sync   <= 1'b0;
      ack_toggle <= 1'b0;
      sel_update <= 1'b0;
    end else begin
      req_meta   <= req_toggle;
      req_sync   <= req_meta;
      ack_toggle <= req_sync;
      sel_update <= req_change;
    end
  end

  // word_latch has been stable since before the request flipped
  always_ff @(posedge data_clk) begin
    if (req_change) begin
      sel_word <= word_latch;
    end
  end

  // no new word may be accepted while a transfer is in flight
  ready_low_during_transfer : assert property (
    @(posedge config_clk) disable iff (config_reset)
    (src_state == cdc_wait_ack) |-> !config_ready
  ) else $error("config_ready high while waiting for ack");

endmodule

`default_nettype wire

// File: src/finite_difference.sv
//==========================================================================
// Per-channel difference stage. Registers each raw sample and its first
// difference against the last valid sample, saturated to 16 bits. Raw
// channel i lands on source i, its difference on source i+8.
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module finite_difference (
  input  wire logic    data_clk,
  input  wire logic    data_reset,
  input  rt_pkg::sample_t adc_data [rt_pkg::phys_channels],
  input  wire logic [rt_pkg::phys_channels-1:0] adc_valid,
  output rt_pkg::sample_t src_data [rt_pkg::input_channels],
  output logic      [rt_pkg::input_channels-1:0] src_valid
);

  import rt_pkg::*;

  // last sample seen with valid high, per channel
  sample_t prev_sample [phys_channels];
  // one extra bit so the subtraction cannot wrap
  logic signed [sample_width:0] diff [phys_channels];

  // clamp a 17 bit difference into the sample range
  function automatic sample_t saturate(input logic signed [sample_width:0] value);
    sample_t result;
    if (value > sample_max) begin
      result = sample_max;
    end else if (value < sample_min) begin
      result = sample_min;
    end else begin
      result = sample_t'(value[sample_width-1:0]);
    end
    return result;
  endfunction

  always_comb begin
    for (int i = 0; i < phys_channels; i++) begin
      diff[i] = (sample_width+1)'(adc_data[i]) - (sample_width+1)'(prev_sample[i]);
    end
  end

  // control state: valid bits and the history
  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      src_valid <= '0;
      for (int i = 0; i < phys_channels; i++) begin
        prev_sample[i] <= '0;
      end
    end else begin
      for (int i = 0; i < phys_channels; i++) begin
        // raw and derived source share the channel strobe
        src_valid[i]               <= adc_valid[i];
        src_valid[i+phys_channels] <= adc_valid[i];
        // history only advances on a valid beat
        if (adc_valid[i]) begin
          prev_sample[i] <= adc_data[i];
        end
      end
    end
  end

  // sample registers, payload only
  always_ff @(posedge data_clk) begin
    for (int i = 0; i < phys_channels; i++) begin
      src_data[i]               <= adc_data[i];
      src_data[i+phys_channels] <= saturate(diff[i]);
    end
  end

endmodule

`default_nettype wire

// File: src/realtime_channel_mux.sv
//==========================================================================
// Registered 16-to-8 channel mux. Each logical output picks one of the
// sixteen sources by a 4 bit index. The index table resets to identity
// and reloads from sel_word whenever sel_update pulses.
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module realtime_channel_mux (
  input  wire logic    data_clk,
  input  wire logic    data_reset,
  input  rt_pkg::sample_t src_data [rt_pkg::input_channels],
  input  wire logic [rt_pkg::input_channels-1:0] src_valid,
  input  wire logic [rt_pkg::config_width-1:0]   sel_word,
  input  wire logic                              sel_update,
  output rt_pkg::sample_t out_data [rt_pkg::output_channels],
  output logic      [rt_pkg::output_channels-1:0] out_valid
);

  import rt_pkg::*;

  // current source index for each logical output
  select_t source_select [output_channels];

  // selection table
  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      for (int j = 0; j < output_channels; j++) begin
        // output j follows physical channel j out of reset
        source_select[j] <= select_t'(j);
      end
    end else if (sel_update) begin
      for (int j = 0; j < output_channels; j++) begin
        source_select[j] <= sel_word[j*select_bits +: select_bits];
      end
    end
  end

  // valid bits follow the selected source
  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      out_valid <= '0;
    end else begin
      for (int j = 0; j < output_channels; j++) begin
        out_valid[j] <= src_valid[source_select[j]];
      end
    end
  end

  // routed samples, no reset on the data path
  // several outputs may share one source
  always_ff @(posedge data_clk) begin
    for (int j = 0; j < output_channels; j++) begin
      out_data[j] <= src_data[source_select[j]];
    end
  end

  // nothing may leave the mux on the first cycle out of reset
  no_valid_after_reset : assert property (
    @(posedge data_clk)
    data_reset |=> (out_valid == '0)
  ) else $error("out_valid set in the cycle after data_reset");

endmodule

`default_nettype wire

// File: src/adc_channel_router.sv
//==========================================================================
// Top of the acquisition front end. ADC samples pass the difference stage
// and the channel mux, two data_clk cycles end to end. The routing table
// is written from config_clk through a valid/ready port.
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module adc_channel_router (
  input  wire logic    data_clk,
  input  wire logic    data_reset,
  input  rt_pkg::sample_t adc_data [rt_pkg::phys_channels],
  input  wire logic [rt_pkg::phys_channels-1:0]   adc_valid,
  output rt_pkg::sample_t out_data [rt_pkg::output_channels],
  output logic      [rt_pkg::output_channels-1:0] out_valid,
  input  wire logic                              config_clk,
  input  wire logic                              config_reset,
  input  wire logic [rt_pkg::config_width-1:0]   config_data,
  input  wire logic                              config_valid,
  output logic                                   config_ready
);

  import rt_pkg::*;

  // raw and derived sources into the mux
  sample_t src_data [input_channels];
  logic [input_channels-1:0] src_valid;

  // routing word after the clock crossing
  logic [config_width-1:0] sel_word;
  logic sel_update;

  // stage 1: raw sample and first difference
  finite_difference finite_difference_i (
    .data_clk  (data_clk),
    .data_reset(data_reset),
    .adc_data  (adc_data),
    .adc_valid (adc_valid),
    .src_data  (src_data),
    .src_valid (src_valid)
  );

  // config word into the data domain
  config_reg_cdc config_reg_cdc_i (
    .config_clk  (config_clk),
    .config_reset(config_reset),
    .config_data (config_data),
    .config_valid(config_valid),
    .config_ready(config_ready),
    .data_clk    (data_clk),
    .data_reset  (data_reset),
    .sel_word    (sel_word),
    .sel_update  (sel_update)
  );

  // stage 2: route sources to logical outputs
  realtime_channel_mux realtime_channel_mux_i (
    .data_clk  (data_clk),
    .data_reset(data_reset),
    .src_data  (src_data),
    .src_valid (src_valid),
    .sel_word  (sel_word),
    .sel_update(sel_update),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
//==========================================================================
// Free-running clock source for the testbench. The period is set in ns
// by parameter, the first rising edge comes half a period after time 0.
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter real period_ns = 20.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2.0) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_adc_channel_router.sv
//==========================================================================
// Table-driven testbench for the ADC channel router. Each row optionally
// writes a routing word, then runs LFSR or full-scale sample beats while a
// model predicts every output two data_clk cycles later.
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_adc_channel_router;

  import rt_pkg::*;

  localparam int data_period_ns = 20;
  localparam int config_period_ns = 30;
  // config cycles allowed for ready to come back
  localparam int ready_wait_limit = 40;

  // config action of a row
  localparam logic [1:0] wr_none = 2'd0;
  localparam logic [1:0] wr_one = 2'd1;
  localparam logic [1:0] wr_pair = 2'd2;
  // stimulus kind of a row
  localparam logic mode_random = 1'b0;
  localparam logic mode_full_scale = 1'b1;

  typedef struct packed {
    logic [1:0]              write;
    logic [config_width-1:0] word_a;
    logic [config_width-1:0] word_b;
    logic                    mode;
    logic [15:0]             beats;
  } step_t;

  localparam int n_steps = 7;
  localparam step_t steps [n_steps] = '{
    // identity routing straight out of reset
    '{wr_none, 32'h0, 32'h0, mode_random, 16'd24},
    // permuted raw channels, outputs 0, 1 and 6 all on channel 3
    '{wr_one, 32'h6317_0533, 32'h0, mode_random, 16'd32},
    // each output on its own difference, full-scale steps saturate both ways
    '{wr_one, 32'hfedc_ba98, 32'h0, mode_full_scale, 16'd12},
    // random valid gaps against the held history
    '{wr_none, 32'h0, 32'h0, mode_random, 16'd32},
    // second word presented while the first is still crossing
    '{wr_pair, 32'h0123_4567, 32'h9a0b_1c2d, mode_random, 16'd32},
    // every output on the difference of channel 0
    '{wr_one, 32'h8888_8888, 32'h0, mode_full_scale, 16'd8},
    '{wr_one, 32'h7654_3210, 32'h0, mode_random, 16'd16}
  };

  logic data_clk;
  logic config_clk;
  logic data_reset;
  logic config_reset;
  sample_t adc_data [phys_channels];
  logic [phys_channels-1:0] adc_valid;
  sample_t out_data [output_channels];
  logic [output_channels-1:0] out_valid;
  logic [config_width-1:0] config_data;
  logic config_valid;
  logic config_ready;

  // model state
  logic [31:0] lfsr_state;
  sample_t model_prev [phys_channels];
  select_t cur_map [output_channels];
  // predictions, eight samples and one valid vector per beat
  sample_t exp_data_q [$];
  logic [output_channels-1:0] exp_valid_q [$];

  tb_clock_gen #(.period_ns(20.0)) data_clock_i (.clk(data_clk));
  tb_clock_gen #(.period_ns(30.0)) config_clock_i (.clk(config_clk));

  adc_channel_router adc_channel_router_i (
    .data_clk    (data_clk),
    .data_reset  (data_reset),
    .adc_data    (adc_data),
    .adc_valid   (adc_valid),
    .out_data    (out_data),
    .out_valid   (out_valid),
    .config_clk  (config_clk),
    .config_reset(config_reset),
    .config_data (config_data),
    .config_valid(config_valid),
    .config_ready(config_ready)
  );

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_sample(input string name, input int idx, input sample_t got,
                              input sample_t exp);
    if (got !== exp) begin
      $display("mismatch %s[%0d] at %0t: got %h, expected %h", name, idx, $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_valid(input string name, input logic [output_channels-1:0] got,
                             input logic [output_channels-1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
      stop_run();
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] bits;
    bits = '0;
    for (int b = 0; b < n; b++) begin
      bits = {bits[14:0], next_bit()};
    end
    return bits;
  endfunction

  // first difference clamped to the signed 16 bit range
  function automatic sample_t saturated_diff(input sample_t cur, input sample_t prev);
    int d;
    d = int'(cur) - int'(prev);
    if (d > 32767) begin
      return sample_t'(16'sh7fff);
    end else if (d < -32768) begin
      return sample_t'(16'sh8000);
    end
    return sample_t'(d);
  endfunction

  // nibble j of the word names the source of output j
  function automatic void load_map(input logic [config_width-1:0] word);
    for (int j = 0; j < output_channels; j++) begin
      cur_map[j] = select_t'(word >> (4 * j));
    end
  endfunction

  // returns on a config_clk falling edge with ready high
  task automatic wait_ready_high();
    int waited;
    waited = 0;
    while (!config_ready) begin
      if (waited == ready_wait_limit) begin
        $display("config_ready stayed low, the config transfer never finished");
        stop_run();
      end
      waited++;
      @(negedge config_clk);
    end
  endtask

  // word is held while ready is low, taken on the next rising edge with ready
  task automatic present_word(input logic [config_width-1:0] word);
    @(negedge config_clk);
    config_data = word;
    config_valid = 1'b1;
    wait_ready_high();
    @(posedge config_clk);
    @(negedge config_clk);
    config_valid = 1'b0;
    check_bit("config_ready", config_ready, 1'b0);
  endtask

  task automatic drive_beat(input logic mode, input int k);
    logic [15:0] r;
    sample_t exp_d;
    logic [output_channels-1:0] exp_v;
    int s;
    int c;
    if (mode == mode_full_scale) begin
      adc_valid = '1;
      for (int i = 0; i < phys_channels; i++) begin
        adc_data[i] = ((k + i) % 2 == 0) ? sample_t'(16'sh7fff) : sample_t'(16'sh8000);
      end
    end else begin
      r = random_bits(phys_channels);
      adc_valid = r[phys_channels-1:0];
      for (int i = 0; i < phys_channels; i++) begin
        adc_data[i] = sample_t'(random_bits(16));
      end
    end
    // sources below 8 are raw, the rest are differences of channel s-8
    for (int j = 0; j < output_channels; j++) begin
      s = int'(cur_map[j]);
      if (s < phys_channels) begin
        exp_d = adc_data[s];
        exp_v[j] = adc_valid[s];
      end else begin
        c = s - phys_channels;
        exp_d = saturated_diff(adc_data[c], model_prev[c]);
        exp_v[j] = adc_valid[c];
      end
      exp_data_q.push_back(exp_d);
    end
    exp_valid_q.push_back(exp_v);
    // history moves only on valid beats
    for (int i = 0; i < phys_channels; i++) begin
      if (adc_valid[i]) begin
        model_prev[i] = adc_data[i];
      end
    end
  endtask

  task automatic check_beat();
    logic [output_channels-1:0] exp_v;
    exp_v = exp_valid_q.pop_front();
    check_valid("out_valid", out_valid, exp_v);
    for (int j = 0; j < output_channels; j++) begin
      check_sample("out_data", j, out_data[j], exp_data_q.pop_front());
    end
  endtask

  // two extra edges drain the pipeline before the next config write
  task automatic run_beats(input logic mode, input int beats);
    for (int k = 0; k < beats + 2; k++) begin
      @(negedge data_clk);
      if (k >= 2) begin
        check_beat();
      end
      if (k < beats) begin
        drive_beat(mode, k);
      end else begin
        adc_valid = '0;
      end
    end
  endtask

  initial begin
    lfsr_state = 32'h51a6;
    data_reset = 1'b1;
    config_reset = 1'b1;
    adc_valid = '0;
    config_data = '0;
    config_valid = 1'b0;
    for (int i = 0; i < phys_channels; i++) begin
      adc_data[i] = '0;
      model_prev[i] = '0;
    end
    for (int j = 0; j < output_channels; j++) begin
      cur_map[j] = select_t'(j);
    end
    fork
      begin
        repeat (4) @(posedge data_clk);
        @(negedge data_clk);
        data_reset = 1'b0;
        check_valid("out_valid", out_valid, '0);
      end
      begin
        repeat (4) @(posedge config_clk);
        @(negedge config_clk);
        config_reset = 1'b0;
        check_bit("config_ready", config_ready, 1'b1);
      end
    join
    for (int s = 0; s < n_steps; s++) begin
      if (steps[s].write != wr_none) begin
        present_word(steps[s].word_a);
        if (steps[s].write == wr_pair) begin
          present_word(steps[s].word_b);
          load_map(steps[s].word_b);
        end else begin
          load_map(steps[s].word_a);
        end
        // new routing is live once ready is back
        wait_ready_high();
      end
      run_beats(steps[s].mode, int'(steps[s].beats));
    end
    $display("Result: PASSED");
    $finish;
  end

  // watchdog, budget from beat counts and config words in the table
  initial begin
    int limit_ns;
    limit_ns = 10 * data_period_ns;
    for (int s = 0; s < n_steps; s++) begin
      limit_ns += (int'(steps[s].beats) + 3) * data_period_ns;
      limit_ns += int'(steps[s].write) * ready_wait_limit * config_period_ns;
    end
    #(2 * limit_ns);
    $display("watchdog expired, the run did not finish in time");
    stop_run();
  end

endmodule

`default_nettype wire

// File: sim.f
src/rt_pkg.sv
src/config_reg_cdc.sv
src/finite_difference.sv
src/realtime_channel_mux.sv
src/adc_channel_router.sv
bench/tb_clock_gen.sv
bench/tb_adc_channel_router.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ADC channel router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_adc_channel_router \
  -f sim.f \
  -o sim_tb

# a failing run exits non-zero, the log is what decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
